// ==== verilog/sd_tx_pkg.sv ====
package sd_tx_pkg;

    // ------------------------------
    // block and line geometry
    // ------------------------------
    localparam int WORD_BITS   = 32;
    localparam int LANES       = 4;
    localparam int CRC_BITS    = 16;
    localparam int BLOCK_WORDS = 128;
    localparam int BUF_DEPTH   = 2;
    localparam int STATUS_BITS = 3;

    // x^16 + x^12 + x^5 + 1
    localparam logic [CRC_BITS-1:0]    CRC_POLY  = 16'h1021;
    // positive crc status token from the card
    localparam logic [STATUS_BITS-1:0] STATUS_OK = 3'b010;

    typedef logic [WORD_BITS-1:0]                 word_t;
    typedef logic [LANES-1:0]                     lane_t;
    typedef logic [CRC_BITS-1:0]                  crc_t;
    typedef logic [STATUS_BITS-1:0]               status_t;
    typedef logic [$clog2(BLOCK_WORDS+1)-1:0]     word_cnt_t;
    typedef logic [$clog2(WORD_BITS)-1:0]         bit_cnt_t;
    typedef logic [$clog2(CRC_BITS)-1:0]          crc_cnt_t;
    typedef logic [$clog2(STATUS_BITS)-1:0]       stat_cnt_t;
    typedef logic [$clog2(BUF_DEPTH)-1:0]         buf_ptr_t;
    typedef logic [$clog2(BUF_DEPTH+1)-1:0]       buf_cnt_t;

    // serializer sequencer
    typedef enum logic [3:0] {
        ST_IDLE        = 4'd0,
        ST_WAIT_WORD   = 4'd1,
        ST_START_BIT   = 4'd2,
        ST_DATA        = 4'd3,
        ST_CRC         = 4'd4,
        ST_END_BIT     = 4'd5,
        ST_STATUS_WAIT = 4'd6,
        ST_STATUS      = 4'd7,
        ST_BUSY        = 4'd8
    } tx_state_t;

endpackage

// ==== verilog/tx_word_fetch.sv ====
`timescale 1ns/1ns

module tx_word_fetch (
    input  logic              in_sd_clk,
    input  logic              hrst_n,
    input  logic              soft_rst_n,
    input  logic              start,
    input  sd_tx_pkg::word_t  fifo_rdata,
    input  logic              full,
    output logic              fifo_re,
    output logic              wr_en,
    output sd_tx_pkg::word_t  wr_data
);

    sd_tx_pkg::word_cnt_t  req_cnt;
    logic                  in_flight;

    // one read at a time, only with room in the buffer
    assign fifo_re = !full && !in_flight && (req_cnt < sd_tx_pkg::BLOCK_WORDS);

    always_ff @(posedge in_sd_clk or negedge hrst_n)
    begin
        if (!hrst_n)
        begin
            // counter parked at the block size so nothing is read before start
            req_cnt   <= sd_tx_pkg::word_cnt_t'(sd_tx_pkg::BLOCK_WORDS);
            in_flight <= 1'b0;
        end
        else if (!soft_rst_n)
        begin
            req_cnt   <= sd_tx_pkg::word_cnt_t'(sd_tx_pkg::BLOCK_WORDS);
            in_flight <= 1'b0;
        end
        else
        begin
            in_flight <= fifo_re;
            if (start)
                req_cnt <= '0;
            else if (fifo_re)
                req_cnt <= req_cnt + 1'b1;
        end
    end

    // fifo data arrives one cycle after the strobe
    assign wr_en = in_flight;

    // byte swap, fifo byte 0 goes out first
    always_comb
    begin
        for (int b = 0; b < sd_tx_pkg::WORD_BITS / 8; b++)
            wr_data[8*b +: 8] = fifo_rdata[sd_tx_pkg::WORD_BITS - 8*(b+1) +: 8];
    end

endmodule

// ==== verilog/tx_word_buffer.sv ====
`timescale 1ns/1ns

module tx_word_buffer (
    input  logic              in_sd_clk,
    input  logic              hrst_n,
    input  logic              soft_rst_n,
    input  logic              wr_en,
    input  sd_tx_pkg::word_t  wr_data,
    input  logic              rd_en,
    output sd_tx_pkg::word_t  rd_data,
    output logic              full,
    output logic              empty
);

    sd_tx_pkg::word_t     mem [sd_tx_pkg::BUF_DEPTH];
    sd_tx_pkg::buf_ptr_t  wr_ptr;
    sd_tx_pkg::buf_ptr_t  rd_ptr;
    sd_tx_pkg::buf_cnt_t  count;
    logic                 push;
    logic                 pop;

    assign push    = wr_en && !full;
    assign pop     = rd_en && !empty;
    assign full    = (count == sd_tx_pkg::BUF_DEPTH);
    assign empty   = (count == 0);
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge in_sd_clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    // ------------------------------
    // pointers and fill count
    // ------------------------------
    always_ff @(posedge in_sd_clk or negedge hrst_n)
    begin
        if (!hrst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (!soft_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == sd_tx_pkg::BUF_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == sd_tx_pkg::BUF_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/crc16_lane.sv ====
`timescale 1ns/1ns

module crc16_lane (
    input  logic  in_sd_clk,
    input  logic  hrst_n,
    input  logic  clear,
    input  logic  shift_in,
    input  logic  in_bit,
    input  logic  shift_out,
    output logic  crc_msb
);

    sd_tx_pkg::crc_t  crc;
    logic             feedback;

    assign feedback = in_bit ^ crc[sd_tx_pkg::CRC_BITS-1];
    assign crc_msb  = crc[sd_tx_pkg::CRC_BITS-1];

    always_ff @(posedge in_sd_clk or negedge hrst_n)
    begin
        if (!hrst_n)
            crc <= '0;
        else if (clear)
            crc <= '0;
        else if (shift_in)
            crc <= {crc[sd_tx_pkg::CRC_BITS-2:0], 1'b0} ^
                   (feedback ? sd_tx_pkg::CRC_POLY : '0);
        else if (shift_out)
            // send phase, the same register empties msb first
            crc <= {crc[sd_tx_pkg::CRC_BITS-2:0], 1'b0};
    end

endmodule

// ==== verilog/dat_line_serializer.sv ====
`timescale 1ns/1ns

module dat_line_serializer (
    input  logic              in_sd_clk,
    input  logic              hrst_n,
    input  logic              soft_rst_n,
    input  logic              start,
    input  logic              data_width,
    input  sd_tx_pkg::word_t  rd_data,
    input  logic              empty,
    input  sd_tx_pkg::lane_t  dat_in,
    output logic              rd_en,
    output sd_tx_pkg::lane_t  dat_out,
    output sd_tx_pkg::lane_t  dat_oe,
    output logic              busy,
    output logic              done,
    output logic              crc_status_wrong
);

    localparam int NIB_LAST = sd_tx_pkg::WORD_BITS / sd_tx_pkg::LANES - 1;

    sd_tx_pkg::tx_state_t  state;
    sd_tx_pkg::word_t      shift_reg;
    sd_tx_pkg::word_t      data_src;
    sd_tx_pkg::word_cnt_t  word_cnt;
    sd_tx_pkg::bit_cnt_t   bit_cnt;
    sd_tx_pkg::crc_cnt_t   crc_cnt;
    sd_tx_pkg::stat_cnt_t  stat_cnt;
    sd_tx_pkg::status_t    status;
    sd_tx_pkg::lane_t      lane_act;
    sd_tx_pkg::lane_t      data_nxt;
    sd_tx_pkg::lane_t      crc_msb;
    sd_tx_pkg::lane_t      crc_shift_in;
    sd_tx_pkg::lane_t      crc_shift_out;
    logic                  group_last;
    logic                  last_word;
    logic                  load_word;
    logic                  feed_crc;
    logic                  send_crc;
    logic                  crc_clear;

    // ------------------------------
    // datapath control
    // ------------------------------
    assign lane_act   = data_width ? '1 : sd_tx_pkg::lane_t'(1);
    assign group_last = data_width ? (bit_cnt == NIB_LAST)
                                   : (bit_cnt == sd_tx_pkg::WORD_BITS - 1);
    assign last_word  = (word_cnt == sd_tx_pkg::BLOCK_WORDS);

    // pop in the cycle before each data group
    assign load_word = (state == sd_tx_pkg::ST_START_BIT) ||
                       ((state == sd_tx_pkg::ST_DATA) && group_last && !last_word);
    assign rd_en     = load_word && !empty;

    assign data_src = load_word ? rd_data : shift_reg;
    // unused lanes stay high in 1-bit mode
    assign data_nxt = data_width ? data_src[sd_tx_pkg::WORD_BITS-1 -: sd_tx_pkg::LANES]
                                 : {{(sd_tx_pkg::LANES-1){1'b1}},
                                    data_src[sd_tx_pkg::WORD_BITS-1]};

    // crc sees each bit as it is loaded into dat_out
    assign feed_crc = (state == sd_tx_pkg::ST_START_BIT) ||
                      ((state == sd_tx_pkg::ST_DATA) && !(group_last && last_word));
    assign send_crc = ((state == sd_tx_pkg::ST_DATA) && group_last && last_word) ||
                      ((state == sd_tx_pkg::ST_CRC) && (crc_cnt != sd_tx_pkg::CRC_BITS - 1));

    assign crc_shift_in  = feed_crc ? lane_act : '0;
    assign crc_shift_out = send_crc ? lane_act : '0;
    assign crc_clear     = !soft_rst_n || ((state == sd_tx_pkg::ST_IDLE) && start);

    for (genvar i = 0; i < sd_tx_pkg::LANES; i++)
    begin : g_crc
        crc16_lane i_crc16_lane (
            .in_sd_clk (in_sd_clk),
            .hrst_n    (hrst_n),
            .clear     (crc_clear),
            .shift_in  (crc_shift_in[i]),
            .in_bit    (data_nxt[i]),
            .shift_out (crc_shift_out[i]),
            .crc_msb   (crc_msb[i])
        );
    end

    always_ff @(posedge in_sd_clk)
    begin
        if (feed_crc)
            shift_reg <= data_width ? (data_src << sd_tx_pkg::LANES) : (data_src << 1);
    end

    // ------------------------------
    // block sequencer
    // ------------------------------
    always_ff @(posedge in_sd_clk or negedge hrst_n)
    begin
        if (!hrst_n)
        begin
            state    <= sd_tx_pkg::ST_IDLE;
            dat_out  <= '1;
            dat_oe   <= '0;
            word_cnt <= '0;
            bit_cnt  <= '0;
            crc_cnt  <= '0;
            stat_cnt <= '0;
            status   <= '0;
        end
        else if (!soft_rst_n)
        begin
            state    <= sd_tx_pkg::ST_IDLE;
            dat_out  <= '1;
            dat_oe   <= '0;
            word_cnt <= '0;
            bit_cnt  <= '0;
            crc_cnt  <= '0;
            stat_cnt <= '0;
            status   <= '0;
        end
        else
        begin
            case (state)
                sd_tx_pkg::ST_IDLE:
                    if (start)
                        state <= sd_tx_pkg::ST_WAIT_WORD;
                sd_tx_pkg::ST_WAIT_WORD:
                    if (!empty)
                    begin
                        // start bit on active lanes
                        state   <= sd_tx_pkg::ST_START_BIT;
                        dat_oe  <= lane_act;
                        dat_out <= ~lane_act;
                    end
                sd_tx_pkg::ST_START_BIT:
                begin
                    state    <= sd_tx_pkg::ST_DATA;
                    dat_out  <= data_nxt;
                    bit_cnt  <= '0;
                    word_cnt <= sd_tx_pkg::word_cnt_t'(1);
                end
                sd_tx_pkg::ST_DATA:
                    if (group_last && last_word)
                    begin
                        state   <= sd_tx_pkg::ST_CRC;
                        dat_out <= crc_msb | ~lane_act;
                        crc_cnt <= '0;
                    end
                    else
                    begin
                        dat_out <= data_nxt;
                        bit_cnt <= group_last ? '0 : bit_cnt + 1'b1;
                        if (load_word)
                            word_cnt <= word_cnt + 1'b1;
                    end
                sd_tx_pkg::ST_CRC:
                    if (crc_cnt == sd_tx_pkg::CRC_BITS - 1)
                    begin
                        state   <= sd_tx_pkg::ST_END_BIT;
                        dat_out <= '1;
                    end
                    else
                    begin
                        dat_out <= crc_msb | ~lane_act;
                        crc_cnt <= crc_cnt + 1'b1;
                    end
                sd_tx_pkg::ST_END_BIT:
                begin
                    // release the lines for the status token
                    state   <= sd_tx_pkg::ST_STATUS_WAIT;
                    dat_oe  <= '0;
                    dat_out <= '1;
                end
                sd_tx_pkg::ST_STATUS_WAIT:
                    if (!dat_in[0])
                    begin
                        state    <= sd_tx_pkg::ST_STATUS;
                        stat_cnt <= '0;
                    end
                sd_tx_pkg::ST_STATUS:
                begin
                    status   <= {status[sd_tx_pkg::STATUS_BITS-2:0], dat_in[0]};
                    stat_cnt <= stat_cnt + 1'b1;
                    if (stat_cnt == sd_tx_pkg::STATUS_BITS - 1)
                        state <= sd_tx_pkg::ST_BUSY;
                end
                sd_tx_pkg::ST_BUSY:
                    if (dat_in[0])
                        state <= sd_tx_pkg::ST_IDLE;
                default:
                    state <= sd_tx_pkg::ST_IDLE;
            endcase
        end
    end

    // card releases dat0 at end of busy
    assign done             = (state == sd_tx_pkg::ST_BUSY) && dat_in[0];
    assign crc_status_wrong = done && (status != sd_tx_pkg::STATUS_OK);
    assign busy             = (state != sd_tx_pkg::ST_IDLE);

endmodule

// ==== verilog/sd_data_tx.sv ====
`timescale 1ns/1ns

module sd_data_tx (
    input  logic              in_sd_clk,
    input  logic              hrst_n,
    input  logic              soft_rst_n,
    input  logic              start,
    input  logic              data_width,
    input  sd_tx_pkg::word_t  fifo_rdata,
    input  sd_tx_pkg::lane_t  dat_in,
    output logic              fifo_re,
    output sd_tx_pkg::lane_t  dat_out,
    output sd_tx_pkg::lane_t  dat_oe,
    output logic              busy,
    output logic              done,
    output logic              crc_status_wrong
);

    logic              wr_en;
    sd_tx_pkg::word_t  wr_data;
    logic              rd_en;
    sd_tx_pkg::word_t  rd_data;
    logic              full;
    logic              empty;

    // fifo side
    tx_word_fetch i_tx_word_fetch (
        .in_sd_clk  (in_sd_clk),
        .hrst_n     (hrst_n),
        .soft_rst_n (soft_rst_n),
        .start      (start),
        .fifo_rdata (fifo_rdata),
        .full       (full),
        .fifo_re    (fifo_re),
        .wr_en      (wr_en),
        .wr_data    (wr_data)
    );

    tx_word_buffer i_tx_word_buffer (
        .in_sd_clk  (in_sd_clk),
        .hrst_n     (hrst_n),
        .soft_rst_n (soft_rst_n),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .full       (full),
        .empty      (empty)
    );

    // card side
    dat_line_serializer i_dat_line_serializer (
        .in_sd_clk        (in_sd_clk),
        .hrst_n           (hrst_n),
        .soft_rst_n       (soft_rst_n),
        .start            (start),
        .data_width       (data_width),
        .rd_data          (rd_data),
        .empty            (empty),
        .dat_in           (dat_in),
        .rd_en            (rd_en),
        .dat_out          (dat_out),
        .dat_oe           (dat_oe),
        .busy             (busy),
        .done             (done),
        .crc_status_wrong (crc_status_wrong)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic  in_sd_clk,
    output logic  hrst_n
);

    // 4 ns period
    initial
    begin
        in_sd_clk = 1'b0;
        forever #2 in_sd_clk = ~in_sd_clk;
    end

    // reset held for two rising edges
    initial
    begin
        hrst_n = 1'b0;
        repeat (2) @(posedge in_sd_clk);
        #1;
        hrst_n = 1'b1;
    end

endmodule

// ==== test/tb_sd_data_tx_assert.sv ====
`timescale 1ns/1ns

module tb_sd_data_tx_assert (
    input logic              in_sd_clk,
    input logic              hrst_n,
    input logic              data_width,
    input logic              fifo_re,
    input sd_tx_pkg::lane_t  dat_oe,
    input logic              busy,
    input logic              done,
    input logic              crc_status_wrong
);

    // lines released outside a transfer
    a_oe_idle: assert property (@(posedge in_sd_clk) disable iff (!hrst_n)
        !busy |-> (dat_oe == '0))
        else $error("dat_oe driven while busy is low");

    a_oe_narrow: assert property (@(posedge in_sd_clk) disable iff (!hrst_n)
        !data_width |-> (dat_oe[3:1] == 3'b000))
        else $error("upper lanes driven in 1-bit mode");

    // one read in flight at a time
    a_re_single: assert property (@(posedge in_sd_clk) disable iff (!hrst_n)
        fifo_re |=> !fifo_re)
        else $error("fifo_re high in two consecutive cycles");

    a_wrong_done: assert property (@(posedge in_sd_clk) disable iff (!hrst_n)
        crc_status_wrong |-> done)
        else $error("crc_status_wrong without done");

endmodule

bind sd_data_tx tb_sd_data_tx_assert i_tb_sd_data_tx_assert (.*);

// ==== test/tb_sd_data_tx.sv ====
`timescale 1ns/1ns

module tb_sd_data_tx;

    // five blocks of at most about 4200 cycles, plus margin
    localparam int TIMEOUT_CYCLES = 30000;

    logic              in_sd_clk;
    logic              hrst_n;
    logic              soft_rst_n;
    logic              start;
    logic              data_width;
    sd_tx_pkg::word_t  fifo_rdata;
    sd_tx_pkg::lane_t  dat_in;
    logic              fifo_re;
    sd_tx_pkg::lane_t  dat_out;
    sd_tx_pkg::lane_t  dat_oe;
    logic              busy;
    logic              done;
    logic              crc_status_wrong;

    sd_tx_pkg::word_t  fifo_words [$];
    logic [31:0]       rng_state;
    logic              re_seen;
    int                cycle_cnt = 0;
    int                check_cnt = 0;
    int                error_cnt = 0;

    tb_clock_gen i_tb_clock_gen (
        .in_sd_clk (in_sd_clk),
        .hrst_n    (hrst_n)
    );

    sd_data_tx i_sd_data_tx (
        .in_sd_clk        (in_sd_clk),
        .hrst_n           (hrst_n),
        .soft_rst_n       (soft_rst_n),
        .start            (start),
        .data_width       (data_width),
        .fifo_rdata       (fifo_rdata),
        .dat_in           (dat_in),
        .fifo_re          (fifo_re),
        .dat_out          (dat_out),
        .dat_oe           (dat_oe),
        .busy             (busy),
        .done             (done),
        .crc_status_wrong (crc_status_wrong)
    );

    // ------------------------------
    // models and helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // fifo byte 0 sits in the low byte
    function automatic sd_tx_pkg::word_t byte_swap(input sd_tx_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic sd_tx_pkg::crc_t crc_step(input sd_tx_pkg::crc_t c, input logic b);
        sd_tx_pkg::crc_t shifted;
        shifted = {c[14:0], 1'b0};
        if (b ^ c[15])
            shifted = shifted ^ sd_tx_pkg::CRC_POLY;
        return shifted;
    endfunction

    task automatic tick();
        @(posedge in_sd_clk);
        #1;
    endtask

    task automatic check_word(input sd_tx_pkg::word_t got, input sd_tx_pkg::word_t exp,
                              input string msg);
        check_cnt++;
        if (got !== exp)
        begin
            error_cnt++;
            $display("** Error at %0t ns: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_lanes(input sd_tx_pkg::lane_t got, input sd_tx_pkg::lane_t exp,
                               input string msg);
        check_cnt++;
        if (got !== exp)
        begin
            error_cnt++;
            $display("** Error at %0t ns: %s: got %b, expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_crc(input sd_tx_pkg::crc_t got, input sd_tx_pkg::crc_t exp,
                             input string msg);
        check_cnt++;
        if (got !== exp)
        begin
            error_cnt++;
            $display("** Error at %0t ns: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        check_cnt++;
        if (got !== exp)
        begin
            error_cnt++;
            $display("** Error at %0t ns: %s: got %b, expected %b", $time, msg, got, exp);
        end
    endtask

    // fifo answers a read strobe one cycle later
    always
    begin
        @(negedge in_sd_clk);
        re_seen = fifo_re;
        @(posedge in_sd_clk);
        #1;
        if (re_seen)
        begin
            rng_state  = xorshift32(rng_state);
            fifo_rdata = rng_state;
            fifo_words.push_back(rng_state);
        end
    end

    always @(posedge in_sd_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("The run did not finish within %0d clock cycles.", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // pulse start, return in the start bit cycle
    task automatic start_block(input logic width);
        tick();
        fifo_words.delete();
        data_width = width;
        start      = 1'b1;
        tick();
        start = 1'b0;
        @(negedge in_sd_clk);
        while (dat_oe == '0)
        begin
            tick();
            @(negedge in_sd_clk);
        end
    endtask

    task automatic run_block(input logic width, input sd_tx_pkg::status_t token,
                             input int busy_cycles);
        sd_tx_pkg::lane_t  samples [$];
        sd_tx_pkg::lane_t  act;
        sd_tx_pkg::word_t  rx_word;
        sd_tx_pkg::word_t  sw;
        sd_tx_pkg::crc_t   rx_crc;
        sd_tx_pkg::crc_t   exp_crc [sd_tx_pkg::LANES];
        int                group;
        int                data_cycles;
        int                lane;

        act         = width ? 4'b1111 : 4'b0001;
        group       = width ? 8 : 32;
        data_cycles = group * sd_tx_pkg::BLOCK_WORDS;
        start_block(width);
        for (int i = 0; i < data_cycles + sd_tx_pkg::CRC_BITS + 2; i++)
        begin
            if (i > 0)
            begin
                tick();
                @(negedge in_sd_clk);
            end
            check_lanes(dat_oe, act, "dat_oe during block");
            check_lanes(dat_out | act, '1, "unused lanes held high");
            samples.push_back(dat_out);
        end
        check_lanes(samples[0] & act, '0, "start bit");
        check_lanes(samples[samples.size()-1], '1, "end bit");
        check_flag(fifo_words.size() == sd_tx_pkg::BLOCK_WORDS, 1'b1, "words read from fifo");

        // ------------------------------
        // data words and lane crcs
        // ------------------------------
        for (int l = 0; l < sd_tx_pkg::LANES; l++)
            exp_crc[l] = '0;
        for (int j = 0; j < sd_tx_pkg::BLOCK_WORDS; j++)
        begin
            rx_word = '0;
            for (int k = 0; k < group; k++)
                rx_word = width ? {rx_word[27:0], samples[1 + group*j + k]}
                                : {rx_word[30:0], samples[1 + group*j + k][0]};
            sw = byte_swap(fifo_words[j]);
            check_word(rx_word, sw, $sformatf("data word %0d", j));
            // in 4-bit mode bit b rides on lane b mod 4
            for (int b = sd_tx_pkg::WORD_BITS - 1; b >= 0; b--)
            begin
                lane          = width ? (b % 4) : 0;
                exp_crc[lane] = crc_step(exp_crc[lane], sw[b]);
            end
        end
        for (int l = 0; l < sd_tx_pkg::LANES; l++)
        begin
            if (act[l])
            begin
                rx_crc = '0;
                for (int c = 0; c < sd_tx_pkg::CRC_BITS; c++)
                    rx_crc = {rx_crc[14:0], samples[1 + data_cycles + c][l]};
                check_crc(rx_crc, exp_crc[l], $sformatf("crc of lane %0d", l));
            end
        end

        // ------------------------------
        // card status token and busy
        // ------------------------------
        tick();
        @(negedge in_sd_clk);
        check_lanes(dat_oe, '0, "dat_oe after end bit");
        tick();
        tick();
        dat_in[0] = 1'b0;
        for (int t = sd_tx_pkg::STATUS_BITS - 1; t >= 0; t--)
        begin
            tick();
            dat_in[0] = token[t];
        end
        for (int n = 0; n < busy_cycles; n++)
        begin
            tick();
            dat_in[0] = 1'b0;
            @(negedge in_sd_clk);
            check_flag(done, 1'b0, "done while card busy");
            check_flag(busy, 1'b1, "busy while card busy");
        end
        tick();
        dat_in[0] = 1'b1;
        @(negedge in_sd_clk);
        check_flag(done, 1'b1, "done at end of card busy");
        check_flag(busy, 1'b1, "busy in the done cycle");
        check_flag(crc_status_wrong, token != sd_tx_pkg::STATUS_OK, "crc status flag");
        tick();
        @(negedge in_sd_clk);
        check_flag(done, 1'b0, "done after its pulse");
        check_flag(busy, 1'b0, "busy after done");
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_one_bit();
        run_block(1'b0, sd_tx_pkg::STATUS_OK, 3);
    endtask

    task automatic test_four_bit();
        run_block(1'b1, sd_tx_pkg::STATUS_OK, 2);
    endtask

    task automatic test_status_error();
        run_block(1'b1, 3'b101, 1);
    endtask

    task automatic test_busy_hold();
        run_block(1'b0, sd_tx_pkg::STATUS_OK, 20);
    endtask

    task automatic test_soft_reset();
        start_block(1'b0);
        repeat (100) tick();
        soft_rst_n = 1'b0;
        tick();
        soft_rst_n = 1'b1;
        @(negedge in_sd_clk);
        check_lanes(dat_oe, '0, "dat_oe after soft reset");
        check_lanes(dat_out, '1, "dat_out after soft reset");
        check_flag(busy, 1'b0, "busy after soft reset");
        repeat (4) tick();
        run_block(1'b0, sd_tx_pkg::STATUS_OK, 0);
    endtask

    initial
    begin
        rng_state  = 32'h6ae;
        soft_rst_n = 1'b1;
        start      = 1'b0;
        data_width = 1'b0;
        fifo_rdata = '0;
        dat_in     = '1;
        // outputs while reset is held
        @(negedge in_sd_clk);
        check_flag(fifo_re, 1'b0, "fifo_re in reset");
        check_flag(busy, 1'b0, "busy in reset");
        check_flag(done, 1'b0, "done in reset");
        check_flag(crc_status_wrong, 1'b0, "crc_status_wrong in reset");
        check_lanes(dat_oe, '0, "dat_oe in reset");
        check_lanes(dat_out, '1, "dat_out in reset");
        @(posedge hrst_n);
        test_one_bit();
        test_four_bit();
        test_status_error();
        test_busy_hold();
        test_soft_reset();
        $display("checks: %0d  errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/sd_tx_pkg.sv
verilog/tx_word_fetch.sv
verilog/tx_word_buffer.sv
verilog/crc16_lane.sv
verilog/dat_line_serializer.sv
verilog/sd_data_tx.sv
test/tb_clock_gen.sv
test/tb_sd_data_tx_assert.sv
test/tb_sd_data_tx.sv
